//--- common/csrPkg.sv
//////////////////////////////////////////////////
// CSR unit shared definitions
// addresses, op codes, mstatus bits, stage payloads
//////////////////////////////////////////////////

package csrPkg;

    // data width of the core
    localparam int xlen = 64;

    // machine CSR addresses
    localparam logic [11:0] csrMstatus  = 12'h300;
    localparam logic [11:0] csrMtvec    = 12'h305;
    localparam logic [11:0] csrMscratch = 12'h340;
    localparam logic [11:0] csrMepc     = 12'h341;
    localparam logic [11:0] csrMcause   = 12'h342;

    // environment call from M-mode
    localparam logic [63:0] causeEcallM = 64'd11;

    // mstatus bit positions
    localparam int mstatusMie   = 3;
    localparam int mstatusMpie  = 7;
    localparam int mstatusMppLo = 11;
    localparam int mstatusMppHi = 12;

    // SYSTEM opcode and the two fixed encodings
    localparam logic [6:0]  opcodeSystem = 7'b1110011;
    localparam logic [31:0] instrEcall   = 32'h0000_0073;
    localparam logic [31:0] instrMret    = 32'h3020_0073;

    typedef enum logic [2:0] {
        opWrite,
        opSet,
        opClear,
        opEcall,
        opMret,
        opIllegal
    } csrOpE;

    // request as it arrives from the core
    typedef struct packed {
        logic [31:0]     instr;
        logic [xlen-1:0] rs1Data;
        logic [xlen-1:0] pc;
    } csrReqT;

    // decoded item between decode and result
    typedef struct packed {
        csrOpE           op;
        logic [11:0]     addr;
        // rs1Data or zero-extended zimm
        logic [xlen-1:0] operand;
        logic [xlen-1:0] pc;
    } csrDecT;

    // response back to the core
    typedef struct packed {
        logic [xlen-1:0] rdData;
        logic            redirect;
        logic [xlen-1:0] redirectPc;
        logic            illegal;
    } csrRespT;

endpackage

//--- hdl/csrDecoder.sv
//////////////////////////////////////////////////
// CSR decode stage
// splits a SYSTEM instruction into op, addr, operand
//////////////////////////////////////////////////

`timescale 1ns/10ps

module csrDecoder (
    input  logic           clk,
    input  logic           arstN,
    input  logic           reqValid,
    output logic           reqReady,
    input  csrPkg::csrReqT req,
    output logic           decValid,
    input  logic           decReady,
    output csrPkg::csrDecT dec
);

    logic [6:0]     opcode;
    logic [2:0]     funct3;
    logic [4:0]     zimm;
    csrPkg::csrDecT decNext;

    assign opcode = req.instr[6:0];
    assign funct3 = req.instr[14:12];
    // rs1 field doubles as the immediate
    assign zimm   = req.instr[19:15];

    always_comb begin
        decNext.op      = csrPkg::opIllegal;
        decNext.addr    = req.instr[31:20];
        decNext.operand = req.rs1Data;
        decNext.pc      = req.pc;
        if (opcode == csrPkg::opcodeSystem) begin
            case (funct3)
                3'd1: decNext.op = csrPkg::opWrite;
                3'd2: decNext.op = csrPkg::opSet;
                3'd3: decNext.op = csrPkg::opClear;
                3'd5: begin
                    decNext.op      = csrPkg::opWrite;
                    decNext.operand = {{(csrPkg::xlen - 5){1'b0}}, zimm};
                end
                3'd6: begin
                    decNext.op      = csrPkg::opSet;
                    decNext.operand = {{(csrPkg::xlen - 5){1'b0}}, zimm};
                end
                3'd7: begin
                    decNext.op      = csrPkg::opClear;
                    decNext.operand = {{(csrPkg::xlen - 5){1'b0}}, zimm};
                end
                3'd0: begin
                    // only the exact encodings count
                    if (req.instr == csrPkg::instrEcall) begin
                        decNext.op = csrPkg::opEcall;
                    end else if (req.instr == csrPkg::instrMret) begin
                        decNext.op = csrPkg::opMret;
                    end
                end
                default: decNext.op = csrPkg::opIllegal;
            endcase
        end
    end

    // stage takes a new item when empty or draining
    assign reqReady = !decValid || decReady;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            decValid <= 1'b0;
        end else if (reqReady) begin
            decValid <= reqValid;
        end
    end

    always_ff @(posedge clk) begin
        if (reqValid && reqReady) begin
            dec <= decNext;
        end
    end

endmodule

//--- csrFile/csrFile.sv
//////////////////////////////////////////////////
// machine CSR storage
// read by address, commit of rmw, ecall and mret
//////////////////////////////////////////////////

`timescale 1ns/10ps

module csrFile (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic [11:0]             addr,
    input  csrPkg::csrOpE           op,
    input  logic                    commit,
    input  logic [csrPkg::xlen-1:0] newValue,
    input  logic [csrPkg::xlen-1:0] pc,
    output logic [csrPkg::xlen-1:0] rdata,
    output logic                    addrKnown,
    output logic [csrPkg::xlen-1:0] mtvec,
    output logic [csrPkg::xlen-1:0] mepc
);

    logic [csrPkg::xlen-1:0] mstatus;
    logic [csrPkg::xlen-1:0] mtvecQ;
    logic [csrPkg::xlen-1:0] mscratch;
    logic [csrPkg::xlen-1:0] mepcQ;
    logic [csrPkg::xlen-1:0] mcause;

    logic isCsrOp;
    logic csrWrite;
    logic ecallCommit;
    logic mretCommit;

    // read side
    always_comb begin
        rdata     = '0;
        addrKnown = 1'b1;
        case (addr)
            csrPkg::csrMstatus:  rdata = mstatus;
            csrPkg::csrMtvec:    rdata = mtvecQ;
            csrPkg::csrMscratch: rdata = mscratch;
            csrPkg::csrMepc:     rdata = mepcQ;
            csrPkg::csrMcause:   rdata = mcause;
            default:             addrKnown = 1'b0;
        endcase
    end

    assign isCsrOp = (op == csrPkg::opWrite) || (op == csrPkg::opSet) ||
                     (op == csrPkg::opClear);

    assign csrWrite    = commit && isCsrOp;
    assign ecallCommit = commit && (op == csrPkg::opEcall);
    assign mretCommit  = commit && (op == csrPkg::opMret);

    // mstatus sees csr writes plus the trap entry and exit
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mstatus <= '0;
        end else if (ecallCommit) begin
            mstatus[csrPkg::mstatusMpie] <= mstatus[csrPkg::mstatusMie];
            mstatus[csrPkg::mstatusMie]  <= 1'b0;
            // previous privilege is always M
            mstatus[csrPkg::mstatusMppHi:csrPkg::mstatusMppLo] <= 2'b11;
        end else if (mretCommit) begin
            mstatus[csrPkg::mstatusMie]  <= mstatus[csrPkg::mstatusMpie];
            mstatus[csrPkg::mstatusMpie] <= 1'b1;
        end else if (csrWrite && addr == csrPkg::csrMstatus) begin
            mstatus <= newValue;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mtvecQ <= '0;
        end else if (csrWrite && addr == csrPkg::csrMtvec) begin
            mtvecQ <= newValue;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mscratch <= '0;
        end else if (csrWrite && addr == csrPkg::csrMscratch) begin
            mscratch <= newValue;
        end
    end

    // ecall saves the pc of the trapping instruction
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mepcQ <= '0;
        end else if (ecallCommit) begin
            mepcQ <= pc;
        end else if (csrWrite && addr == csrPkg::csrMepc) begin
            mepcQ <= newValue;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mcause <= '0;
        end else if (ecallCommit) begin
            mcause <= csrPkg::causeEcallM;
        end else if (csrWrite && addr == csrPkg::csrMcause) begin
            mcause <= newValue;
        end
    end

    // redirect targets for the result stage
    assign mtvec = mtvecQ;
    assign mepc  = mepcQ;

endmodule

//--- hdl/csrResult.sv
//////////////////////////////////////////////////
// CSR result stage
// builds write value and response, holds it for output
//////////////////////////////////////////////////

`timescale 1ns/10ps

module csrResult (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    decValid,
    output logic                    decReady,
    input  csrPkg::csrDecT          dec,
    input  logic [csrPkg::xlen-1:0] rdata,
    input  logic                    addrKnown,
    input  logic [csrPkg::xlen-1:0] mtvec,
    input  logic [csrPkg::xlen-1:0] mepc,
    output logic                    commit,
    output logic [csrPkg::xlen-1:0] newValue,
    output logic                    respValid,
    input  logic                    respReady,
    output csrPkg::csrRespT         resp
);

    logic            isCsrOp;
    logic            illegal;
    csrPkg::csrRespT respNext;

    assign isCsrOp = (dec.op == csrPkg::opWrite) || (dec.op == csrPkg::opSet) ||
                     (dec.op == csrPkg::opClear);

    // unknown csr address only raises the illegal flag
    assign illegal = (dec.op == csrPkg::opIllegal) || (isCsrOp && !addrKnown);

    always_comb begin
        case (dec.op)
            csrPkg::opSet:   newValue = rdata | dec.operand;
            csrPkg::opClear: newValue = rdata & ~dec.operand;
            default:         newValue = dec.operand;
        endcase
    end

    assign decReady = !respValid || respReady;
    assign commit   = decValid && decReady && !illegal;

    always_comb begin
        respNext.rdData     = (isCsrOp && !illegal) ? rdata : '0;
        respNext.redirect   = (dec.op == csrPkg::opEcall) || (dec.op == csrPkg::opMret);
        respNext.redirectPc = '0;
        respNext.illegal    = illegal;
        if (dec.op == csrPkg::opEcall) begin
            respNext.redirectPc = mtvec;
        end else if (dec.op == csrPkg::opMret) begin
            respNext.redirectPc = mepc;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            respValid <= 1'b0;
        end else if (decReady) begin
            respValid <= decValid;
        end
    end

    always_ff @(posedge clk) begin
        if (decValid && decReady) begin
            resp <= respNext;
        end
    end

endmodule

//--- hdl/csrUnit.sv
//////////////////////////////////////////////////
// CSR unit top level
// decode, CSR file and result stage
//////////////////////////////////////////////////

`timescale 1ns/10ps

module csrUnit (
    input  logic            clk,
    input  logic            arstN,
    input  logic            reqValid,
    output logic            reqReady,
    input  csrPkg::csrReqT  req,
    output logic            respValid,
    input  logic            respReady,
    output csrPkg::csrRespT resp
);

    logic                    decValid;
    logic                    decReady;
    csrPkg::csrDecT          dec;
    logic [csrPkg::xlen-1:0] rdata;
    logic                    addrKnown;
    logic [csrPkg::xlen-1:0] mtvec;
    logic [csrPkg::xlen-1:0] mepc;
    logic                    commit;
    logic [csrPkg::xlen-1:0] newValue;

    csrDecoder csrDecoder_i (
        .clk      (clk),
        .arstN    (arstN),
        .reqValid (reqValid),
        .reqReady (reqReady),
        .req      (req),
        .decValid (decValid),
        .decReady (decReady),
        .dec      (dec)
    );

    // state updates on the edge the item enters the result register
    csrFile csrFile_i (
        .clk       (clk),
        .arstN     (arstN),
        .addr      (dec.addr),
        .op        (dec.op),
        .commit    (commit),
        .newValue  (newValue),
        .pc        (dec.pc),
        .rdata     (rdata),
        .addrKnown (addrKnown),
        .mtvec     (mtvec),
        .mepc      (mepc)
    );

    csrResult csrResult_i (
        .clk       (clk),
        .arstN     (arstN),
        .decValid  (decValid),
        .decReady  (decReady),
        .dec       (dec),
        .rdata     (rdata),
        .addrKnown (addrKnown),
        .mtvec     (mtvec),
        .mepc      (mepc),
        .commit    (commit),
        .newValue  (newValue),
        .respValid (respValid),
        .respReady (respReady),
        .resp      (resp)
    );

endmodule

//--- sim/csrUnitTb.sv
//////////////////////////////////////////////////
// CSR unit testbench
// table of SYSTEM instructions, random output stall
//////////////////////////////////////////////////

`timescale 1ns/10ps

module csrUnitTb;

    localparam int timeoutCycles = 100;
    localparam int randomSeed    = 88014;

    logic            clk;
    logic            arstN;
    logic            reqValid;
    logic            reqReady;
    csrPkg::csrReqT  req;
    logic            respValid;
    logic            respReady;
    csrPkg::csrRespT resp;

    // stimulus and expected response table
    string           names[$];
    logic [31:0]     instrs[$];
    logic [63:0]     rs1Values[$];
    logic [63:0]     pcs[$];
    csrPkg::csrRespT expects[$];

    int errorCount;
    int received;
    bit timedOut;

    csrUnit csrUnit_i (
        .clk       (clk),
        .arstN     (arstN),
        .reqValid  (reqValid),
        .reqReady  (reqReady),
        .req       (req),
        .respValid (respValid),
        .respReady (respReady),
        .resp      (resp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // I-type SYSTEM encoding with rd fixed to x1
    function automatic logic [31:0] encodeCsr(input logic [11:0] addr,
                                              input logic [2:0] funct3,
                                              input logic [4:0] rs1Field);
        return {addr, rs1Field, funct3, 5'd1, 7'b1110011};
    endfunction

    function automatic void addEntry(input string name, input logic [31:0] instr,
                                     input logic [63:0] rs1Data, input logic [63:0] pc,
                                     input csrPkg::csrRespT expected);
        names.push_back(name);
        instrs.push_back(instr);
        rs1Values.push_back(rs1Data);
        pcs.push_back(pc);
        expects.push_back(expected);
    endfunction

    // csr access returns the old value and no redirect
    function automatic void csrOp(input string name, input logic [11:0] addr,
                                  input logic [2:0] funct3, input logic [4:0] rs1Field,
                                  input logic [63:0] rs1Data, input logic [63:0] oldValue);
        csrPkg::csrRespT expected;
        expected.rdData     = oldValue;
        expected.redirect   = 1'b0;
        expected.redirectPc = '0;
        expected.illegal    = 1'b0;
        addEntry(name, encodeCsr(addr, funct3, rs1Field), rs1Data,
                 64'h1000 + 64'(names.size() * 4), expected);
    endfunction

    function automatic void readCsr(input string name, input logic [11:0] addr,
                                    input logic [63:0] value);
        csrOp(name, addr, 3'd2, 5'd0, 64'd0, value);
    endfunction

    function automatic void trapOp(input string name, input logic [31:0] instr,
                                   input logic [63:0] pc, input logic [63:0] target);
        csrPkg::csrRespT expected;
        expected.rdData     = '0;
        expected.redirect   = 1'b1;
        expected.redirectPc = target;
        expected.illegal    = 1'b0;
        addEntry(name, instr, 64'd0, pc, expected);
    endfunction

    function automatic void illegalOp(input string name, input logic [31:0] instr,
                                      input logic [63:0] rs1Data);
        csrPkg::csrRespT expected;
        expected.rdData     = '0;
        expected.redirect   = 1'b0;
        expected.redirectPc = '0;
        expected.illegal    = 1'b1;
        addEntry(name, instr, rs1Data, 64'h1000 + 64'(names.size() * 4), expected);
    endfunction

    function automatic void buildTable();
        readCsr("reset mstatus", 12'h300, 64'd0);
        readCsr("reset mtvec", 12'h305, 64'd0);
        readCsr("reset mscratch", 12'h340, 64'd0);
        readCsr("reset mepc", 12'h341, 64'd0);
        readCsr("reset mcause", 12'h342, 64'd0);
        csrOp("write mscratch", 12'h340, 3'd1, 5'd2, 64'h1234_5678_9abc_def0, 64'd0);
        csrOp("write mtvec", 12'h305, 3'd1, 5'd3, 64'h0000_0000_8000_0100, 64'd0);
        readCsr("readback mscratch", 12'h340, 64'h1234_5678_9abc_def0);
        readCsr("readback mtvec", 12'h305, 64'h0000_0000_8000_0100);
        csrOp("set mscratch", 12'h340, 3'd2, 5'd4, 64'h0f00_0000_0000_000f,
              64'h1234_5678_9abc_def0);
        csrOp("clear mscratch", 12'h340, 3'd3, 5'd5, 64'h0000_0000_ffff_0000,
              64'h1f34_5678_9abc_deff);
        readCsr("mscratch after clear", 12'h340, 64'h1f34_5678_0000_deff);
        // immediate forms ignore rs1Data
        csrOp("seti mstatus", 12'h300, 3'd6, 5'd8, '1, 64'd0);
        csrOp("cleari mscratch", 12'h340, 3'd7, 5'h1f, '1, 64'h1f34_5678_0000_deff);
        readCsr("mscratch after cleari", 12'h340, 64'h1f34_5678_0000_dee0);
        readCsr("mstatus after seti", 12'h300, 64'h8);
        trapOp("ecall", 32'h0000_0073, 64'h2040, 64'h0000_0000_8000_0100);
        readCsr("mepc after ecall", 12'h341, 64'h2040);
        readCsr("mcause after ecall", 12'h342, 64'd11);
        // MPIE takes the old MIE while MIE clears and MPP goes to 3
        readCsr("mstatus after ecall", 12'h300, 64'h1880);
        trapOp("mret", 32'h3020_0073, 64'h3000, 64'h2040);
        readCsr("mstatus after mret", 12'h300, 64'h1888);
        // second trap pair starts with MPIE low
        csrOp("clear mpie", 12'h300, 3'd3, 5'd9, 64'h80, 64'h1888);
        trapOp("mret with mpie low", 32'h3020_0073, 64'h3004, 64'h2040);
        readCsr("mstatus after mret 2", 12'h300, 64'h1880);
        trapOp("ecall with mie low", 32'h0000_0073, 64'h2080, 64'h0000_0000_8000_0100);
        readCsr("mstatus after ecall 2", 12'h300, 64'h1800);
        illegalOp("unknown address", encodeCsr(12'h7c0, 3'd1, 5'd6), 64'hdead_beef);
        illegalOp("bad funct3", encodeCsr(12'h340, 3'd4, 5'd7), '1);
        readCsr("mscratch unchanged", 12'h340, 64'h1f34_5678_0000_dee0);
        csrOp("writei mepc", 12'h341, 3'd5, 5'h15, '1, 64'h2080);
        readCsr("mepc after writei", 12'h341, 64'h15);
        readCsr("mstatus unchanged", 12'h300, 64'h1800);
    endfunction

    task automatic compareResp(input string name, input csrPkg::csrRespT expected,
                               input csrPkg::csrRespT actual, output bit match);
        match = (actual === expected);
        if (!match) begin
            errorCount++;
            $write("Fail %s expected rd=%h redirect=%b target=%h illegal=%b", name,
                   expected.rdData, expected.redirect, expected.redirectPc, expected.illegal);
            $display(" actual rd=%h redirect=%b target=%h illegal=%b",
                     actual.rdData, actual.redirect, actual.redirectPc, actual.illegal);
        end
    endtask

    task automatic driveRequests();
        int i;
        int waitCycles;
        i = 0;
        while (i < names.size() && !timedOut) begin
            reqValid    <= 1'b1;
            req.instr   <= instrs[i];
            req.rs1Data <= rs1Values[i];
            req.pc      <= pcs[i];
            waitCycles = 0;
            @(posedge clk);
            // hold the request until the decoder takes it
            while (!reqReady && !timedOut) begin
                waitCycles++;
                if (waitCycles > timeoutCycles) begin
                    $display("Timeout: request %s was never accepted", names[i]);
                    timedOut = 1'b1;
                end else begin
                    @(posedge clk);
                end
            end
            i++;
        end
        reqValid <= 1'b0;
    endtask

    task automatic collectResponses();
        int idleCycles;
        int extraCycles;
        bit match;
        idleCycles = 0;
        while (received < names.size() && !timedOut) begin
            @(posedge clk);
            if (respValid && respReady) begin
                compareResp(names[received], expects[received], resp, match);
                $display("%-24s %s", names[received], match ? "ok" : "mismatch");
                received++;
                idleCycles = 0;
            end else begin
                idleCycles++;
                if (idleCycles > timeoutCycles) begin
                    $display("Timeout: no response for %s", names[received]);
                    timedOut = 1'b1;
                end
            end
            // stall about one cycle in three
            respReady <= ($urandom % 3) != 0;
        end
        respReady <= 1'b1;
        if (!timedOut) begin
            for (extraCycles = 0; extraCycles < 4; extraCycles++) begin
                @(posedge clk);
                if (respValid) begin
                    $display("Unexpected response after the last table entry");
                    errorCount++;
                end
            end
        end
    endtask

    initial begin
        void'($urandom(randomSeed));
        arstN      = 1'b0;
        reqValid   = 1'b0;
        req        = '0;
        respReady  = 1'b0;
        errorCount = 0;
        received   = 0;
        timedOut   = 1'b0;
        buildTable();
        repeat (5) @(posedge clk);
        arstN <= 1'b1;
        @(posedge clk);
        fork
            driveRequests();
            collectResponses();
        join
        $display("%0d entries, %0d responses, %0d errors, timeout %0s", names.size(),
                 received, errorCount, timedOut ? "yes" : "no");
        if (errorCount == 0 && !timedOut && received == names.size()) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- csrUnit.f
common/csrPkg.sv
hdl/csrDecoder.sv
csrFile/csrFile.sv
hdl/csrResult.sv
hdl/csrUnit.sv
sim/csrUnitTb.sv

//--- Makefile
# Verilator build and run for the CSR unit

VERILATOR ?= verilator
TOP       ?= csrUnitTb
FILELIST  ?= csrUnit.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= Test passed

SOURCES := $(shell cat $(FILELIST))
SIM     := $(OBJDIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJDIR VFLAGS PASS_TEXT"

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# the run passes only if the pass line shows up in the output
test: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(OBJDIR)
